// ==== gb_loader_top.f ====
+incdir+logic
logic/download_pkg.sv
logic/backup_pkg.sv
logic/download_if.sv
logic/download_decoder.sv
logic/bootrom_checker.sv
logic/cheat_code_loader.sv
logic/backup_sequencer.sv
logic/gb_loader_top.sv
dv/tb_gb_loader_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the loader testbench with Verilator and runs it from the project root.
# The simulator exits with a failing status when the testbench stops on an error.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
	-f gb_loader_top.f \
	--top-module tb_gb_loader_top \
	--Mdir obj_dir \
	-o sim_tb_gb_loader_top

./obj_dir/sim_tb_gb_loader_top

// ==== dv/gb_loader_trace.txt ====
# ops: test <name> | start <index> | write <addr> <data> | fill <count> <data> | end | load | save
# mount <mounted> <readonly> <ram_mask> | wait <cycles> | run <is_save> <blocks> | expect <output> <value>
test reset
expect sd_rd 0
expect sd_wr 0
expect bk_busy 0
expect gg_valid 0
expect custom_cgb_boot 0
expect boot_gba_available 1
test cheat
start ff
write 0 1111
write 2 2222
write 4 3333
write 6 4444
write 8 5555
write a 6666
write c 7777
write e 8888
end
expect gg_pulses 1
expect gg_code 22221111444433336666555588887777
test cheat_under_cart
start 01
write 0 aaaa
write e bbbb
end
expect gg_pulses 1
expect gg_code 22221111444433336666555588887777
test checksum_original
start 04
fill 379 ffff
expect cgb_checksum 2f30a
write 2f6 00e0
expect cgb_checksum 2f3ea
expect real_cgb_boot 1
expect boot_gba_available 1
end
test checksum_other
start 04
write 0 1234
expect cgb_checksum 46
expect custom_cgb_boot 1
expect real_cgb_boot 0
expect boot_gba_available 0
end
test auto_load
mount 1 0 3
start 01
write 0 0000
end
run 0 4
test save
save
run 1 4
test no_mount
mount 0 0 3
start 01
end
load
wait 6
expect requests 0
expect bk_busy 0

// ==== dv/tb_gb_loader_top.sv ====
////////////////////
// Self-checking testbench for the loader top level. Runs the operations of
// the trace file in order and models the host side of the storage handshake.
// Run from the project root so the trace file is found.
////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "loader_defs.svh"

module tb_gb_loader_top;

	logic                       clk_sys;
	logic                       reset;
	logic                       ioctl_download;
	logic                       ioctl_wr;
	logic [`LOADER_ADDR_W-1:0]  ioctl_addr;
	logic [`LOADER_WORD_W-1:0]  ioctl_dout;
	logic [`LOADER_INDEX_W-1:0] ioctl_index;
	logic                       img_mounted;
	logic                       img_readonly;
	logic [`BLOCK_W-1:0]        ram_mask;
	logic                       bk_load;
	logic                       bk_save;
	logic                       sd_ack;
	wire  [`BLOCK_W-1:0]        sd_lba;
	wire                        sd_rd;
	wire                        sd_wr;
	wire                        bk_busy;
	wire                        bk_loading;
	wire  [`CHECKSUM_W-1:0]     cgb_checksum;
	wire                        custom_cgb_boot;
	wire                        real_cgb_boot;
	wire                        boot_gba_available;
	wire  [`GG_CODE_W-1:0]      gg_code;
	wire                        gg_valid;

	// Requests seen by the host model as {bk_loading, sd_rd, sd_wr, sd_lba}
	logic [`BLOCK_W+2:0] request_q[$];
	int                  next_request;
	int                  gg_pulses;
	int                  watchdog_cycles;
	logic [15:0]         lfsr;
	string               test_name;

	gb_loader_top i_dut (.*);

	always #20 clk_sys = ~clk_sys;

	//////////////////////
	// Helpers
	//////////////////////

	// 16-bit Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// Host delay of 0 to 7 cycles built from three LFSR bits
	task automatic random_wait();
		int delay;
		delay = 0;
		for (int i = 0; i < 3; i++) begin
			lfsr  = lfsr_step(lfsr);
			delay = delay * 2 + (lfsr[0] ? 1 : 0);
		end
		repeat (delay) @(posedge clk_sys);
	endtask

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_value(input string what, input logic [127:0] expected,
			input logic [127:0] actual);
		if (actual !== expected)
			abort_run($sformatf("ERR %s/%s expected %0h actual %0h",
				test_name, what, expected, actual));
	endtask

	// Stops on a trace line that lacks fields its operation needs
	task automatic require_fields(input int got, input int want, input string op);
		if (got != want)
			abort_run($sformatf("trace line for %s has %0d of %0d fields",
				op, got, want));
	endtask

	task automatic write_word(input logic [`LOADER_ADDR_W-1:0] addr,
			input logic [`LOADER_WORD_W-1:0] data);
		@(posedge clk_sys);
		ioctl_addr <= addr;
		ioctl_dout <= data;
		ioctl_wr   <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
	endtask

	task automatic pulse(input logic save);
		@(posedge clk_sys);
		bk_load <= !save;
		bk_save <= save;
		@(posedge clk_sys);
		bk_load <= 1'b0;
		bk_save <= 1'b0;
	endtask

	// Outputs settle two cycles after the last input change
	task automatic check_output(input string name, input logic [127:0] expected);
		logic [127:0] actual;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		case (name)
			"sd_rd":              actual = 128'(sd_rd);
			"sd_wr":              actual = 128'(sd_wr);
			"bk_busy":            actual = 128'(bk_busy);
			"bk_loading":         actual = 128'(bk_loading);
			"gg_valid":           actual = 128'(gg_valid);
			"gg_pulses":          actual = 128'(gg_pulses);
			"gg_code":            actual = 128'(gg_code);
			"cgb_checksum":       actual = 128'(cgb_checksum);
			"custom_cgb_boot":    actual = 128'(custom_cgb_boot);
			"real_cgb_boot":      actual = 128'(real_cgb_boot);
			"boot_gba_available": actual = 128'(boot_gba_available);
			"requests":           actual = 128'(request_q.size() - next_request);
			default: abort_run({"trace names an unknown output: ", name});
		endcase
		check_value(name, expected, actual);
	endtask

	// Waits out one backup run and checks its requests block by block
	task automatic check_run(input logic is_save, input int blocks);
		logic [`BLOCK_W+2:0] req;
		@(negedge clk_sys);
		while (!bk_busy)
			@(negedge clk_sys);
		while (bk_busy)
			@(negedge clk_sys);
		check_value("requests", 128'(blocks), 128'(request_q.size() - next_request));
		for (int i = 0; i < blocks; i++) begin
			req = request_q[next_request + i];
			check_value("sd_lba", 128'(i), 128'(req[`BLOCK_W-1:0]));
			check_value("sd_wr", 128'(is_save), 128'(req[`BLOCK_W]));
			check_value("sd_rd", 128'(!is_save), 128'(req[`BLOCK_W+1]));
			check_value("bk_loading", 128'(!is_save), 128'(req[`BLOCK_W+2]));
		end
		next_request = next_request + blocks;
	endtask

	//////////////////////
	// Monitors
	//////////////////////

	always @(negedge clk_sys) begin
		if (reset)
			gg_pulses <= 0;
		else if (gg_valid)
			gg_pulses <= gg_pulses + 1;
	end

	// Host side of the storage handshake with random ack delays
	initial begin : host_model
		sd_ack = 1'b0;
		lfsr   = 16'd62214;
		forever begin
			@(negedge clk_sys);
			if (sd_rd || sd_wr) begin
				request_q.push_back({bk_loading, sd_rd, sd_wr, sd_lba});
				random_wait();
				@(posedge clk_sys);
				sd_ack <= 1'b1;
				@(negedge clk_sys);
				while (sd_rd || sd_wr)
					@(negedge clk_sys);
				random_wait();
				@(posedge clk_sys);
				sd_ack <= 1'b0;
			end
		end
	end

	initial begin : watchdog
		wait (watchdog_cycles > 0);
		repeat (watchdog_cycles) @(posedge clk_sys);
		abort_run($sformatf("timeout, the trace did not finish within %0d cycles",
			watchdog_cycles));
	end

	//////////////////////
	// Trace runner
	//////////////////////

	initial begin : run_trace
		int               fd;
		int               lines;
		int               status;
		int               count;
		logic [8*32-1:0]  word;
		logic [127:0]     arg_a;
		logic [127:0]     arg_b;
		logic [127:0]     arg_c;
		logic [8*256-1:0] line_buf;
		string            op;

		clk_sys        = 1'b0;
		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_index    = '0;
		img_mounted    = 1'b0;
		img_readonly   = 1'b0;
		ram_mask       = '0;
		bk_load        = 1'b0;
		bk_save        = 1'b0;
		next_request   = 0;
		test_name      = "none";

		// Trace length sets the time limit
		fd = $fopen("dv/gb_loader_trace.txt", "r");
		if (fd == 0)
			abort_run("could not open the trace file dv/gb_loader_trace.txt");
		lines = 0;
		while ($fgets(line_buf, fd) != 0)
			lines++;
		$fclose(fd);
		watchdog_cycles = lines * 200;

		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;

		fd = $fopen("dv/gb_loader_trace.txt", "r");
		while ($fscanf(fd, "%s", word) == 1) begin
			op = string'(word);
			case (op)
				"#": status = $fgets(line_buf, fd);
				"test": begin
					status = $fscanf(fd, "%s", word);
					require_fields(status, 1, op);
					test_name = string'(word);
				end
				"start": begin
					status = $fscanf(fd, "%h", arg_a);
					require_fields(status, 1, op);
					@(posedge clk_sys);
					ioctl_index    <= arg_a[`LOADER_INDEX_W-1:0];
					ioctl_addr     <= '0;
					ioctl_download <= 1'b1;
				end
				"write": begin
					status = $fscanf(fd, "%h %h", arg_a, arg_b);
					require_fields(status, 2, op);
					write_word(arg_a[`LOADER_ADDR_W-1:0], arg_b[`LOADER_WORD_W-1:0]);
				end
				"fill": begin
					status = $fscanf(fd, "%d %h", count, arg_b);
					require_fields(status, 2, op);
					for (int i = 0; i < count; i++)
						write_word(`LOADER_ADDR_W'(2 * i), arg_b[`LOADER_WORD_W-1:0]);
				end
				"end": begin
					@(posedge clk_sys);
					ioctl_download <= 1'b0;
					ioctl_wr       <= 1'b0;
				end
				"mount": begin
					status = $fscanf(fd, "%h %h %h", arg_a, arg_b, arg_c);
					require_fields(status, 3, op);
					@(posedge clk_sys);
					img_mounted  <= arg_a[0];
					img_readonly <= arg_b[0];
					ram_mask     <= arg_c[`BLOCK_W-1:0];
				end
				"load": pulse(1'b0);
				"save": pulse(1'b1);
				"wait": begin
					status = $fscanf(fd, "%d", count);
					require_fields(status, 1, op);
					repeat (count) @(posedge clk_sys);
				end
				"run": begin
					status = $fscanf(fd, "%h %d", arg_a, count);
					require_fields(status, 2, op);
					check_run(arg_a[0], count);
				end
				"expect": begin
					status = $fscanf(fd, "%s %h", word, arg_b);
					require_fields(status, 2, op);
					check_output(string'(word), arg_b);
				end
				default: abort_run({"trace holds an unknown operation: ", op});
			endcase
		end
		$fclose(fd);
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== logic/gb_loader_top.sv ====
////////////////////
// Top of the download and backup RAM control path. Connects the decoder
// to its three consumers over one download interface.
////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "loader_defs.svh"

module gb_loader_top (
	input  wire                       clk_sys,
	input  wire                       reset,
	// Host download bus
	input  wire                       ioctl_download,
	input  wire                       ioctl_wr,
	input  wire [`LOADER_ADDR_W-1:0]  ioctl_addr,
	input  wire [`LOADER_WORD_W-1:0]  ioctl_dout,
	input  wire [`LOADER_INDEX_W-1:0] ioctl_index,
	// Backup RAM control and storage handshake
	input  wire                       img_mounted,
	input  wire                       img_readonly,
	input  wire [`BLOCK_W-1:0]        ram_mask,
	input  wire                       bk_load,
	input  wire                       bk_save,
	input  wire                       sd_ack,
	output wire [`BLOCK_W-1:0]        sd_lba,
	output wire                       sd_rd,
	output wire                       sd_wr,
	output wire                       bk_busy,
	output wire                       bk_loading,
	// Bootrom status
	output wire [`CHECKSUM_W-1:0]     cgb_checksum,
	output wire                       custom_cgb_boot,
	output wire                       real_cgb_boot,
	output wire                       boot_gba_available,
	// Cheat code
	output wire [`GG_CODE_W-1:0]      gg_code,
	output wire                       gg_valid
);

	download_if dl ();

	download_decoder i_decoder (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_index    (ioctl_index),
		.dl             (dl.source)
	);

	bootrom_checker i_bootrom (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.dl                 (dl.sink),
		.cgb_checksum       (cgb_checksum),
		.custom_cgb_boot    (custom_cgb_boot),
		.real_cgb_boot      (real_cgb_boot),
		.boot_gba_available (boot_gba_available)
	);

	cheat_code_loader i_cheat (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.dl       (dl.sink),
		.gg_code  (gg_code),
		.gg_valid (gg_valid)
	);

	backup_sequencer i_backup (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.ram_mask     (ram_mask),
		.bk_load      (bk_load),
		.bk_save      (bk_save),
		.sd_ack       (sd_ack),
		.dl           (dl.sink),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.bk_busy      (bk_busy),
		.bk_loading   (bk_loading)
	);

endmodule

`default_nettype wire

// ==== logic/backup_sequencer.sv ====
////////////////////
// Backup RAM save and load, one 512-byte block per storage request.
// Runs walk blocks 0 to ram_mask over the rd/wr with ack handshake.
////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "loader_defs.svh"

module backup_sequencer (
	input  wire                  clk_sys,
	input  wire                  reset,
	input  wire                  img_mounted,
	input  wire                  img_readonly,
	input  wire [`BLOCK_W-1:0]   ram_mask,
	input  wire                  bk_load,
	input  wire                  bk_save,
	input  wire                  sd_ack,
	download_if.sink             dl,
	output logic [`BLOCK_W-1:0]  sd_lba,
	output logic                 sd_rd,
	output logic                 sd_wr,
	output logic                 bk_busy,
	output logic                 bk_loading
);

	backup_pkg::backup_state_e state;
	backup_pkg::backup_op_e    op;

	logic cart_dl;
	logic cart_dl_q;
	logic load_q;
	logic save_q;
	logic bk_ena;
	logic load_rise;
	logic save_rise;
	logic cart_end;

	assign cart_dl   = dl.active && (dl.kind == download_pkg::kind_cart);
	assign load_rise = bk_load && !load_q;
	assign save_rise = bk_save && !save_q;
	assign cart_end  = cart_dl_q && !cart_dl;

	//////////////////////
	// Backup enable
	//////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_dl_q <= 1'b0;
			load_q    <= 1'b0;
			save_q    <= 1'b0;
			bk_ena    <= 1'b0;
		end else begin
			cart_dl_q <= cart_dl;
			load_q    <= bk_load;
			save_q    <= bk_save;
			if (cart_dl && !cart_dl_q) begin
				bk_ena <= 1'b0;
			end
			// The save image is mounted while the cart is still loading
			if (cart_dl && img_mounted && !img_readonly) begin
				bk_ena <= 1'b1;
			end
		end
	end

	//////////////////////
	// Block FSM
	//////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state  <= backup_pkg::st_idle;
			op     <= backup_pkg::op_load;
			sd_lba <= '0;
		end else begin
			case (state)
				backup_pkg::st_idle: begin
					if (bk_ena && (load_rise || save_rise || cart_end)) begin
						state  <= backup_pkg::st_request;
						sd_lba <= '0;
						// Load wins when both arrive together
						op <= (load_rise || cart_end) ? backup_pkg::op_load :
							backup_pkg::op_save;
					end
				end
				backup_pkg::st_request: begin
					if (sd_ack) begin
						state <= backup_pkg::st_wait_release;
					end
				end
				backup_pkg::st_wait_release: begin
					// Ack was high on entry, so low here is its falling edge
					if (!sd_ack) begin
						if (sd_lba == ram_mask) begin
							state <= backup_pkg::st_idle;
						end else begin
							state  <= backup_pkg::st_request;
							sd_lba <= sd_lba + 1'b1;
						end
					end
				end
				default: state <= backup_pkg::st_idle;
			endcase
		end
	end

	assign sd_rd      = (state == backup_pkg::st_request) && (op == backup_pkg::op_load);
	assign sd_wr      = (state == backup_pkg::st_request) && (op == backup_pkg::op_save);
	assign bk_busy    = (state != backup_pkg::st_idle);
	assign bk_loading = bk_busy && (op == backup_pkg::op_load);

endmodule

`default_nettype wire

// ==== logic/cheat_code_loader.sv ====
////////////////////
// Collects eight cheat download words into one code and strobes gg_valid
// when the last word at offset 14 arrives.
////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "loader_defs.svh"

module cheat_code_loader (
	input  wire                    clk_sys,
	input  wire                    reset,
	download_if.sink               dl,
	output logic [`GG_CODE_W-1:0]  gg_code,
	output logic                   gg_valid
);

	logic                  cheat_wr;
	logic [`GG_CODE_W-1:0] stage;
	logic [`GG_CODE_W-1:0] stage_next;

	assign cheat_wr = dl.wr && (dl.kind == download_pkg::kind_cheat);

	// Layout {flags, address, compare, replace}, low word at the lower offset
	always_comb begin
		stage_next = stage;
		if (cheat_wr) begin
			case (dl.addr[3:0])
				4'd0:  stage_next[111:96]  = dl.data;
				4'd2:  stage_next[127:112] = dl.data;
				4'd4:  stage_next[79:64]   = dl.data;
				4'd6:  stage_next[95:80]   = dl.data;
				4'd8:  stage_next[47:32]   = dl.data;
				4'd10: stage_next[63:48]   = dl.data;
				4'd12: stage_next[15:0]    = dl.data;
				4'd14: stage_next[31:16]   = dl.data;
				default: stage_next = stage;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		stage <= stage_next;
		// Output only moves when a code is complete
		if (cheat_wr && dl.addr[3:0] == 4'd14) begin
			gg_code <= stage_next;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			gg_valid <= 1'b0;
		else
			gg_valid <= cheat_wr && (dl.addr[3:0] == 4'd14);
	end

endmodule

`default_nettype wire

// ==== logic/bootrom_checker.sv ====
////////////////////
// Byte-sum checksum of a loaded colour bootrom and the boot status flags
// derived from it.
////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "loader_defs.svh"

module bootrom_checker (
	input  wire                   clk_sys,
	input  wire                   reset,
	download_if.sink              dl,
	output logic [`CHECKSUM_W-1:0] cgb_checksum,
	output logic                  custom_cgb_boot,
	output logic                  real_cgb_boot,
	output logic                  boot_gba_available
);

	logic                   boot_dl;
	logic                   boot_dl_q;
	logic [`CHECKSUM_W-1:0] word_sum;

	assign boot_dl = (dl.kind == download_pkg::kind_cgb_boot);

	// Both bytes of the incoming word, zero extended
	assign word_sum = {{(`CHECKSUM_W-8){1'b0}}, dl.data[`LOADER_WORD_W-1:8]} +
		{{(`CHECKSUM_W-8){1'b0}}, dl.data[7:0]};

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			boot_dl_q       <= 1'b0;
			cgb_checksum    <= '0;
			custom_cgb_boot <= 1'b0;
		end else begin
			boot_dl_q <= boot_dl;
			if (boot_dl) begin
				custom_cgb_boot <= 1'b1;
			end
			// New download restarts the sum
			if (boot_dl && !boot_dl_q)
				cgb_checksum <= dl.wr ? word_sum : '0;
			else if (boot_dl && dl.wr)
				cgb_checksum <= cgb_checksum + word_sum;
		end
	end

	assign real_cgb_boot = (cgb_checksum == `CHECKSUM_ORIGINAL_CGB);

	// GBA mode needs the stock bootrom, the original one or the project-built one
	assign boot_gba_available = !custom_cgb_boot || real_cgb_boot ||
		(cgb_checksum == `CHECKSUM_CUSTOM_CGB);

endmodule

`default_nettype wire

// ==== logic/download_decoder.sv ====
////////////////////
// Input stage of the host download bus. Registers the bus once and
// tags every word with the file kind derived from the file index.
////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "loader_defs.svh"

module download_decoder (
	input  wire                       clk_sys,
	input  wire                       reset,
	input  wire                       ioctl_download,
	input  wire                       ioctl_wr,
	input  wire [`LOADER_ADDR_W-1:0]  ioctl_addr,
	input  wire [`LOADER_WORD_W-1:0]  ioctl_dout,
	input  wire [`LOADER_INDEX_W-1:0] ioctl_index,
	download_if.source                dl
);

	download_pkg::file_kind_e kind_next;

	// Index map, idle bus reads as no kind
	always_comb begin
		if (!ioctl_download)
			kind_next = download_pkg::kind_none;
		else if (ioctl_index[5:0] == download_pkg::CART_INDEX_LOW ||
				ioctl_index == download_pkg::CART_INDEX_ALT)
			kind_next = download_pkg::kind_cart;
		else if (ioctl_index == download_pkg::CGB_BOOT_INDEX)
			kind_next = download_pkg::kind_cgb_boot;
		else if (ioctl_index == download_pkg::CHEAT_INDEX)
			kind_next = download_pkg::kind_cheat;
		else
			kind_next = download_pkg::kind_other;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl.active <= 1'b0;
			dl.wr     <= 1'b0;
			dl.kind   <= download_pkg::kind_none;
		end else begin
			dl.active <= ioctl_download;
			dl.wr     <= ioctl_download && ioctl_wr;
			dl.kind   <= kind_next;
		end
	end

	always_ff @(posedge clk_sys) begin
		dl.addr <= ioctl_addr;
		dl.data <= ioctl_dout;
	end

endmodule

`default_nettype wire

// ==== logic/download_if.sv ====
////////////////////
// Decoded download word, driven by the decoder and read by the consumers.
// A word is valid in the cycle where wr is high, there is no back-pressure.
////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "loader_defs.svh"

interface download_if;

	logic                       active;
	logic                       wr;
	logic [`LOADER_ADDR_W-1:0]  addr;
	logic [`LOADER_WORD_W-1:0]  data;
	download_pkg::file_kind_e   kind;

	modport source (
		output active, wr, addr, data, kind
	);

	modport sink (
		input active, wr, addr, data, kind
	);

endinterface

`default_nettype wire

// ==== logic/backup_pkg.sv ====
////////////////////
// State and operation types of the backup RAM sequencer.
////////////////////
`default_nettype none

package backup_pkg;

	typedef enum logic [1:0] {
		st_idle,
		st_request,
		st_wait_release
	} backup_state_e;

	typedef enum logic [0:0] {
		op_load,
		op_save
	} backup_op_e;

endpackage

`default_nettype wire

// ==== logic/download_pkg.sv ====
////////////////////
// Download file kinds and the host file index values behind them.
////////////////////
`default_nettype none

package download_pkg;

	typedef enum logic [2:0] {
		kind_none,
		kind_cart,
		kind_cgb_boot,
		kind_cheat,
		kind_other
	} file_kind_e;

	// Cart images use index low bits 1, or the full value 0x80
	localparam logic [5:0] CART_INDEX_LOW = 6'h01;
	localparam logic [7:0] CART_INDEX_ALT = 8'h80;
	localparam logic [7:0] CGB_BOOT_INDEX = 8'h04;
	localparam logic [7:0] CHEAT_INDEX    = 8'hFF;

endpackage

`default_nettype wire

// ==== logic/loader_defs.svh ====
////////////////////
// Widths and checksum constants shared by the download and backup RAM path.
// Include this wherever a port or register width is needed.
////////////////////
`ifndef LOADER_DEFS_SVH
`define LOADER_DEFS_SVH

// Host download bus
`define LOADER_WORD_W 16
`define LOADER_ADDR_W 25
`define LOADER_INDEX_W 8

// Colour bootrom checksum
`define CHECKSUM_W 18
`define CHECKSUM_CUSTOM_CGB 18'h2CE10
`define CHECKSUM_ORIGINAL_CGB 18'h2F3EA

// Cheat payload is flags, address, compare and replace, 32 bits each
`define GG_CODE_W 128

// Backup RAM block number, one block is 512 bytes
`define BLOCK_W 8

`endif
